// File: flist.f
+incdir+testbench
hw/win_pkg.sv
hw/col_if.sv
hw/win_if.sv
hw/line_buffer.sv
hw/window_shift.sv
hw/window_reduce.sv
hw/window_filter_top.sv
testbench/tb_window_filter.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the window filter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_window_filter \
  -f flist.f \
  -o sim_window_filter

./obj_dir/sim_window_filter

// File: testbench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Galois form of x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_q = 32'hc655;

// Pixels of the frame being sent, indexed [row][col]
pix_t img [IMG_H][IMG_W];

// One LFSR step per returned bit, first bit ends up in the MSB
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] val;
  logic        bit_out;
  val = '0;
  for (int i = 0; i < n; i++) begin
    bit_out = lfsr_q[0];
    lfsr_q  = lfsr_q >> 1;
    if (bit_out) begin
      lfsr_q = lfsr_q ^ LFSR_TAPS;
    end
    val = {val[30:0], bit_out};
  end
  return val;
endfunction

function automatic void fill_random();
  for (int r = 0; r < IMG_H; r++) begin
    for (int c = 0; c < IMG_W; c++) begin
      img[r][c] = pix_t'(rand_bits(PIX_W));
    end
  end
endfunction

function automatic void fill_const(pix_t v);
  for (int r = 0; r < IMG_H; r++) begin
    for (int c = 0; c < IMG_W; c++) begin
      img[r][c] = v;
    end
  end
endfunction

// Window whose lower-right pixel sits at (row, col)
function automatic res_t window_ref(filter_op_e op, int row, int col);
  int acc;
  int p;
  acc = (op == OP_MIN) ? (1 << PIX_W) - 1 : 0;
  for (int r = row - WIN + 1; r <= row; r++) begin
    for (int c = col - WIN + 1; c <= col; c++) begin
      p = int'(img[r][c]);
      if (op == OP_SUM) begin
        acc = acc + p;
      end else if (op == OP_MAX) begin
        acc = (p > acc) ? p : acc;
      end else begin
        acc = (p < acc) ? p : acc;
      end
    end
  end
  return res_t'(acc);
endfunction

`endif

// File: testbench/tb_window_filter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_window_filter;
  import win_pkg::*;

  localparam int IMG_W       = 12;
  localparam int IMG_H       = 8;
  localparam int FRAME_PIX   = IMG_W * IMG_H;
  localparam int DRAIN_LIMIT = 40;

  logic       clk;
  logic       rst_n;
  logic       pix_valid_i;
  logic       sof_i;
  pix_t       pix_i;
  filter_op_e op_i;
  logic       res_valid_o;
  res_t       res_o;

  res_t       exp_q [$];
  res_t       exp_val;
  logic       win_done;    // Pixel on this cycle completes a window
  logic [3:0] done_sr;

  `include "tb_ref_model.svh"

  window_filter_top #(
    .IMG_W(IMG_W),
    .IMG_H(IMG_H)
  ) dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_valid_i(pix_valid_i),
    .sof_i      (sof_i),
    .pix_i      (pix_i),
    .op_i       (op_i),
    .res_valid_o(res_valid_o),
    .res_o      (res_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Window completions delayed by the pipeline depth
  always @(posedge clk) begin
    if (!rst_n) begin
      done_sr <= '0;
    end else begin
      done_sr <= {done_sr[2:0], win_done};
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) res_valid_o == done_sr[3])
    else begin
      $display("res_valid_o not four cycles after the last pixel of its window");
      $display("test failed");
      $fatal(1, "result timing");
    end

  // Each result against the head of the expected queue
  always @(negedge clk) begin
    if (res_valid_o === 1'b1) begin
      assert (exp_q.size() != 0) else begin
        $display("res_valid_o high while no result was expected");
        $display("test failed");
        $fatal(1, "unexpected result");
      end
      exp_val = exp_q.pop_front();
      assert (res_o == exp_val) else begin
        $display("mismatch res_o: got %h expected %h", res_o, exp_val);
        $display("test failed");
        $fatal(1, "wrong result");
      end
    end
  end

  task automatic apply_reset();
    @(negedge clk);
    rst_n       = 1'b0;
    pix_valid_i = 1'b0;
    sof_i       = 1'b0;
    win_done    = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    exp_q.delete();  // Anything still in flight was dropped by the reset
  endtask

  // Leaves the last pixel driven so that a following frame starts back to back
  task automatic send_frame(filter_op_e op, bit gaps, int npix);
    int n_idle;
    int r;
    int c;
    for (int idx = 0; idx < npix; idx++) begin
      r      = idx / IMG_W;
      c      = idx % IMG_W;
      n_idle = gaps ? int'(rand_bits(2)) : 0;
      repeat (n_idle) begin
        @(negedge clk);
        pix_valid_i = 1'b0;
        sof_i       = 1'b0;
        win_done    = 1'b0;
      end
      @(negedge clk);
      pix_valid_i = 1'b1;
      sof_i       = (idx == 0);
      pix_i       = img[r][c];
      if (idx == IMG_W) begin
        op_i = op;  // Previous frame has left stage one by now
      end
      win_done = (r >= WIN - 1) && (c >= WIN - 1);
      if (win_done) begin
        exp_q.push_back(window_ref(op, r, c));
      end
    end
  endtask

  task automatic drain_check();
    int cycles;
    @(negedge clk);
    pix_valid_i = 1'b0;
    sof_i       = 1'b0;
    win_done    = 1'b0;
    cycles      = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        $display("timeout with %0d results still missing", exp_q.size());
        $display("test failed");
        $fatal(1, "drain timeout");
      end
    end
    repeat (2 * WIN) @(negedge clk);  // A stray result would show up here
  endtask

  initial begin
    rst_n       = 1'b0;
    pix_valid_i = 1'b0;
    sof_i       = 1'b0;
    pix_i       = '0;
    op_i        = OP_SUM;
    win_done    = 1'b0;
    apply_reset();

    fill_random();
    send_frame(OP_SUM, 1'b0, FRAME_PIX);
    drain_check();

    fill_random();
    send_frame(OP_MAX, 1'b0, FRAME_PIX);
    drain_check();
    fill_random();
    send_frame(OP_MIN, 1'b0, FRAME_PIX);
    drain_check();
    fill_const(8'hff);  // Full-scale sum needs all result bits
    send_frame(OP_SUM, 1'b0, FRAME_PIX);
    drain_check();

    // Same picture with and without idle cycles
    fill_random();
    send_frame(OP_SUM, 1'b0, FRAME_PIX);
    drain_check();
    send_frame(OP_SUM, 1'b1, FRAME_PIX);
    drain_check();

    // Reset in the middle of a frame
    fill_random();
    send_frame(OP_SUM, 1'b0, 70);
    apply_reset();
    fill_random();
    send_frame(OP_MIN, 1'b0, FRAME_PIX);
    drain_check();

    // New frame starts before the old one is complete
    fill_random();
    send_frame(OP_MAX, 1'b1, 67);
    fill_random();
    send_frame(OP_MAX, 1'b0, FRAME_PIX);
    drain_check();

    fill_random();
    send_frame(OP_SUM, 1'b0, FRAME_PIX);
    fill_random();
    send_frame(OP_MAX, 1'b0, FRAME_PIX);
    fill_random();
    send_frame(OP_MIN, 1'b1, FRAME_PIX);
    drain_check();

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/window_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module window_filter_top #(
  parameter int IMG_W = 16,
  parameter int IMG_H = 10
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pix_valid_i,
  input  logic                sof_i,
  input  win_pkg::pix_t       pix_i,
  input  win_pkg::filter_op_e op_i,
  output logic                res_valid_o,
  output win_pkg::res_t       res_o
);

  col_if col_bus ();
  win_if win_bus ();

  // Pixel stream to vertical columns
  line_buffer #(
    .IMG_W(IMG_W),
    .IMG_H(IMG_H)
  ) u_line_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_valid_i(pix_valid_i),
    .sof_i      (sof_i),
    .pix_i      (pix_i),
    .col_o      (col_bus.src)
  );

  // Columns to full 5x5 window
  window_shift #(
    .IMG_W(IMG_W)
  ) u_window_shift (
    .clk  (clk),
    .rst_n(rst_n),
    .col_i(col_bus.dst),
    .win_o(win_bus.src)
  );

  window_reduce u_window_reduce (
    .clk        (clk),
    .rst_n      (rst_n),
    .win_i      (win_bus.dst),
    .op_i       (op_i),
    .res_valid_o(res_valid_o),
    .res_o      (res_o)
  );

endmodule

`default_nettype wire

// File: hw/window_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module window_reduce (
  input  logic                clk,
  input  logic                rst_n,
  win_if.dst                  win_i,
  input  win_pkg::filter_op_e op_i,
  output logic                res_valid_o,
  output win_pkg::res_t       res_o
);
  import win_pkg::*;

  // Combine WIN values under one opcode
  function automatic res_t reduce_row(filter_op_e op, res_t [WIN-1:0] v);
    res_t acc;
    acc = v[0];
    for (int i = 1; i < WIN; i++) begin
      case (op)
        OP_SUM: acc = acc + v[i];
        OP_MAX: begin
          if (v[i] > acc) begin
            acc = v[i];
          end
        end
        OP_MIN: begin
          if (v[i] < acc) begin
            acc = v[i];
          end
        end
        default: acc = '0;
      endcase
    end
    return acc;
  endfunction

  res_t [WIN-1:0] row_vals [WIN];
  res_t [WIN-1:0] part_c;

  // Stage one registers
  res_t [WIN-1:0] part_q;
  filter_op_e     op_q;
  logic           vld1_q;

  // Stage two registers
  res_t res_q;
  logic vld2_q;

  // Pixels are zero-extended so max and min come out in res_t
  always_comb begin
    for (int r = 0; r < WIN; r++) begin
      for (int c = 0; c < WIN; c++) begin
        row_vals[r][c] = res_t'(win_i.win_pix[r*WIN + c]);
      end
      part_c[r] = reduce_row(op_i, row_vals[r]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld1_q <= 1'b0;
      op_q   <= OP_SUM;
      vld2_q <= 1'b0;
    end else begin
      vld1_q <= win_i.win_valid;
      vld2_q <= vld1_q;
      if (win_i.win_valid) begin
        op_q <= op_i;  // Follows its partials into stage two
      end
    end
  end

  always_ff @(posedge clk) begin
    if (win_i.win_valid) begin
      part_q <= part_c;
    end
    if (vld1_q) begin
      res_q <= reduce_row(op_q, part_q);
    end
  end

  assign res_valid_o = vld2_q;
  assign res_o       = res_q;

endmodule

`default_nettype wire

// File: hw/window_shift.sv
`timescale 1ns/1ps
`default_nettype none

module window_shift #(
  parameter int IMG_W = 16
) (
  input  logic clk,
  input  logic rst_n,
  col_if.dst   col_i,
  win_if.src   win_o
);
  import win_pkg::*;

  // Counter sized to span a full row
  localparam int CNT_W = $clog2(((IMG_W > WIN) ? IMG_W : WIN) + 1);

  // One shift row per window row, [0] is the newest column
  pix_t [WIN-1:0] shift_q [WIN];

  logic [CNT_W-1:0]   fill_cnt;
  logic [CNT_W-1:0]   fill_nxt;
  logic               win_valid_q;
  pix_t [WIN*WIN-1:0] win_pix;

  always_comb begin
    if (col_i.col_sol) begin
      fill_nxt = CNT_W'(1);
    end else if (fill_cnt < CNT_W'(WIN)) begin
      fill_nxt = fill_cnt + 1'b1;
    end else begin
      fill_nxt = fill_cnt;  // Saturate once the window is full
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill_cnt    <= '0;
      win_valid_q <= 1'b0;
    end else begin
      win_valid_q <= col_i.col_valid && col_i.col_rows_ok && (fill_nxt == CNT_W'(WIN));
      if (col_i.col_valid) begin
        fill_cnt <= fill_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (col_i.col_valid) begin
      for (int r = 0; r < WIN; r++) begin
        shift_q[r] <= {shift_q[r][WIN-2:0], col_i.col_pix[r]};
      end
    end
  end

  // Oldest column first within each row
  always_comb begin
    for (int r = 0; r < WIN; r++) begin
      for (int c = 0; c < WIN; c++) begin
        win_pix[r*WIN + c] = shift_q[r][WIN-1-c];
      end
    end
  end

  assign win_o.win_valid = win_valid_q;
  assign win_o.win_pix   = win_pix;

endmodule

`default_nettype wire

// File: hw/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
  parameter int IMG_W = 16,
  parameter int IMG_H = 10
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          pix_valid_i,
  input  logic          sof_i,
  input  win_pkg::pix_t pix_i,
  col_if.src            col_o
);
  import win_pkg::*;

  localparam int CW   = (IMG_W > 1) ? $clog2(IMG_W) : 1;
  localparam int RW   = (IMG_H > 1) ? $clog2(IMG_H) : 1;
  localparam int NROW = WIN - 1;  // Previous rows kept in memory

  logic [CW-1:0] col_cnt;
  logic [CW-1:0] cur_col;
  logic [RW-1:0] row_cnt;
  logic [RW-1:0] cur_row;

  // [NROW-1] holds the previous row, [0] the oldest
  pix_t row_mem [NROW][IMG_W];

  pix_t [WIN-1:0] col_pix_q;
  logic           col_valid_q;
  logic           rows_ok_q;
  logic           sol_q;

  // Position of the pixel being accepted, sof forces the origin
  assign cur_col = sof_i ? '0 : col_cnt;
  assign cur_row = sof_i ? '0 : row_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (pix_valid_i) begin
      if (cur_col == CW'(IMG_W - 1)) begin
        col_cnt <= '0;
        row_cnt <= (cur_row == RW'(IMG_H - 1)) ? '0 : cur_row + 1'b1;
      end else begin
        col_cnt <= cur_col + 1'b1;
        row_cnt <= cur_row;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_valid_q <= 1'b0;
      rows_ok_q   <= 1'b0;
      sol_q       <= 1'b0;
    end else begin
      col_valid_q <= pix_valid_i;
      if (pix_valid_i) begin
        rows_ok_q <= (cur_row >= RW'(WIN - 1));
        sol_q     <= (cur_col == '0);
      end
    end
  end

  // Read the stored column, then shift the history up by one row
  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      col_pix_q[WIN-1] <= pix_i;
      for (int k = 0; k < NROW; k++) begin
        col_pix_q[k] <= row_mem[k][cur_col];
      end
      for (int k = 0; k < NROW - 1; k++) begin
        row_mem[k][cur_col] <= row_mem[k+1][cur_col];
      end
      row_mem[NROW-1][cur_col] <= pix_i;
    end
  end

  assign col_o.col_valid   = col_valid_q;
  assign col_o.col_pix     = col_pix_q;
  assign col_o.col_rows_ok = rows_ok_q;
  assign col_o.col_sol     = sol_q;

endmodule

`default_nettype wire

// File: hw/win_if.sv
`timescale 1ns/1ps
`default_nettype none

interface win_if;
  import win_pkg::*;

  logic win_valid;

  // Row-major, [0] is the oldest column of the oldest row
  pix_t [WIN*WIN-1:0] win_pix;

  modport src (output win_valid, output win_pix);
  modport dst (input win_valid, input win_pix);

endinterface

`default_nettype wire

// File: hw/col_if.sv
`timescale 1ns/1ps
`default_nettype none

interface col_if;
  import win_pkg::*;

  logic           col_valid;
  pix_t [WIN-1:0] col_pix;      // [0] oldest row, [WIN-1] current row
  logic           col_rows_ok;  // Enough rows stored for a full window
  logic           col_sol;      // First column of a row

  modport src (output col_valid, output col_pix, output col_rows_ok, output col_sol);
  modport dst (input col_valid, input col_pix, input col_rows_ok, input col_sol);

endinterface

`default_nettype wire

// File: hw/win_pkg.sv
`default_nettype none

package win_pkg;

  // Pixel format
  localparam int PIX_W = 8;

  // Window side in pixels
  localparam int WIN = 5;

  // Wide enough for the sum of a full window of max-valued pixels
  localparam int RES_W = $clog2(WIN * WIN * ((1 << PIX_W) - 1) + 1);

  typedef logic [PIX_W-1:0] pix_t;

  typedef logic [RES_W-1:0] res_t;

  // Reduction applied over the window
  typedef enum logic [1:0] {
    OP_SUM = 2'd0,
    OP_MAX = 2'd1,
    OP_MIN = 2'd2
  } filter_op_e;

endpackage

`default_nettype wire
